// File: design/axil_mem_bridge.sv
// AXI4-Lite subordinate that serves one transaction at a time.
// Each address is decoded into the boot ROM, the main SRAM or a hole,
// and the matching memory gets a single-cycle request. Holes answer
// DECERR, writes to the ROM answer SLVERR.

`timescale 1ns/1ps

module axil_mem_bridge (
  input  logic                             clk_i,
  input  logic                             ndmreset_n,
  input  axil_pkg::axil_req_t              axil_req_i,
  output axil_pkg::axil_resp_t             axil_resp_o,
  output harness_pkg::mem_req_t            rom_req_o,
  input  logic [axil_pkg::DataWidth-1:0]   rom_rdata_i,
  output harness_pkg::mem_req_t            sram_req_o,
  input  logic [axil_pkg::DataWidth-1:0]   sram_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_WAIT,
    READ_RESP
  } state_e;

  typedef enum logic [1:0] {
    RegionNone,
    RegionRom,
    RegionSram
  } region_e;

  state_e                                  state_q, state_d;
  region_e                                 region_q, region_d;
  region_e                                 acc_region;
  axil_pkg::axil_resp_e                    resp_q, resp_d;
  logic [axil_pkg::DataWidth-1:0]          rdata_q;
  logic [axil_pkg::DataWidth-1:0]          rdata_sel;
  logic                                    write_go;
  logic                                    read_go;
  logic [axil_pkg::AddrWidth-1:0]          acc_addr;
  logic [harness_pkg::WordAddrWidth-1:0]   acc_index;

  function automatic region_e decode_region(input logic [axil_pkg::AddrWidth-1:0] addr);
    region_e region;
    region = RegionNone;
    if (addr >= harness_pkg::RomBase &&
        addr < harness_pkg::RomBase + harness_pkg::RomLength) begin
      region = RegionRom;
    end else if (addr >= harness_pkg::SramBase &&
                 addr < harness_pkg::SramBase + harness_pkg::SramLength) begin
      region = RegionSram;
    end
    return region;
  endfunction

  // Byte offset from the region base, in 64-bit words
  function automatic logic [harness_pkg::WordAddrWidth-1:0] word_index(
    input logic [axil_pkg::AddrWidth-1:0] addr,
    input region_e                        region
  );
    logic [axil_pkg::AddrWidth-1:0] offset;
    offset = '0;
    if (region == RegionRom) begin
      offset = addr - harness_pkg::RomBase;
    end else if (region == RegionSram) begin
      offset = addr - harness_pkg::SramBase;
    end
    return offset[harness_pkg::WordAddrWidth+2:3];
  endfunction

  // --------------------------------------------------------------------------
  // Handshake and decode
  // --------------------------------------------------------------------------
  // AW and W are taken together, and a write wins over a pending read
  assign write_go = (state_q == IDLE) & axil_req_i.aw_valid & axil_req_i.w_valid;
  assign read_go  = (state_q == IDLE) & axil_req_i.ar_valid &
                    ~(axil_req_i.aw_valid & axil_req_i.w_valid);

  assign acc_addr   = write_go ? axil_req_i.aw_addr : axil_req_i.ar_addr;
  assign acc_region = decode_region(acc_addr);
  assign acc_index  = word_index(acc_addr, acc_region);

  // Requests are issued in the handshake cycle itself
  always_comb begin
    rom_req_o            = '0;
    rom_req_o.req        = read_go & (acc_region == RegionRom);
    rom_req_o.word_addr  = acc_index;

    sram_req_o           = '0;
    sram_req_o.req       = (write_go | read_go) & (acc_region == RegionSram);
    sram_req_o.we        = write_go;
    sram_req_o.word_addr = acc_index;
    sram_req_o.be        = axil_req_i.w_strb;
    sram_req_o.wdata     = axil_req_i.w_data;
  end

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    region_d = region_q;
    resp_d   = resp_q;
    unique case (state_q)
      IDLE: begin
        if (write_go) begin
          state_d  = WRITE_RESP;
          region_d = acc_region;
          unique case (acc_region)
            RegionSram: resp_d = axil_pkg::OKAY;
            RegionRom:  resp_d = axil_pkg::SLVERR;
            default:    resp_d = axil_pkg::DECERR;
          endcase
        end else if (read_go) begin
          state_d  = READ_WAIT;
          region_d = acc_region;
          resp_d   = (acc_region == RegionNone) ? axil_pkg::DECERR : axil_pkg::OKAY;
        end
      end
      WRITE_RESP: begin
        if (axil_req_i.b_ready) begin
          state_d = IDLE;
        end
      end
      // Memory output is valid here, one edge after the request
      READ_WAIT: state_d = READ_RESP;
      READ_RESP: begin
        if (axil_req_i.r_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q  <= IDLE;
      region_q <= RegionNone;
      resp_q   <= axil_pkg::OKAY;
    end else begin
      state_q  <= state_d;
      region_q <= region_d;
      resp_q   <= resp_d;
    end
  end

  // --------------------------------------------------------------------------
  // Read data capture
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (region_q)
      RegionRom:  rdata_sel = rom_rdata_i;
      RegionSram: rdata_sel = sram_rdata_i;
      default:    rdata_sel = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (state_q == READ_WAIT) begin
      rdata_q <= rdata_sel;
    end
  end

  always_comb begin
    axil_resp_o          = '0;
    axil_resp_o.aw_ready = write_go;
    axil_resp_o.w_ready  = write_go;
    axil_resp_o.ar_ready = read_go;
    axil_resp_o.b_valid  = (state_q == WRITE_RESP);
    axil_resp_o.b_resp   = resp_q;
    axil_resp_o.r_valid  = (state_q == READ_RESP);
    axil_resp_o.r_data   = rdata_q;
    axil_resp_o.r_resp   = resp_q;
  end

endmodule

// File: design/axil_pkg.sv
// AXI4-Lite bus definitions shared by the memory bridge and its testbench.
// Channel signals travel as two packed structs, one per direction, so a
// port carries a whole bus side in a single connection.

package axil_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Response codes on B and R
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Manager to subordinate
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    axil_resp_e           b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    axil_resp_e           r_resp;
  } axil_resp_t;

endpackage

// File: design/boot_rom.sv
// Boot ROM with contents computed from the word index.
// A request registers the addressed word on the same edge. Write fields
// of the request carry no meaning here.

`timescale 1ns/1ps

module boot_rom (
  input  logic                           clk_i,
  input  harness_pkg::mem_req_t          rom_req_i,
  output logic [axil_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IndexWidth = $clog2(harness_pkg::RomWords);

  logic [IndexWidth-1:0] index;
  logic [31:0]           index_ext;

  // Only the ROM's own index bits matter
  assign index     = rom_req_i.word_addr[IndexWidth-1:0];
  assign index_ext = 32'(index);

  // Upper half signature plus index, lower half inverted index
  always_ff @(posedge clk_i) begin
    if (rom_req_i.req) begin
      rdata_o <= {harness_pkg::RomSignature + index_ext, ~index_ext};
    end
  end

endmodule

// File: design/data_sram.sv
// Main memory of the harness, 64-bit words with byte enables.
// Single port: a request either writes the enabled bytes or registers
// the addressed word on its edge.

`timescale 1ns/1ps

module data_sram (
  input  logic                           clk_i,
  input  harness_pkg::mem_req_t          sram_req_i,
  output logic [axil_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IndexWidth = $clog2(harness_pkg::SramWords);

  logic [axil_pkg::DataWidth-1:0] mem [harness_pkg::SramWords];
  logic [IndexWidth-1:0]          index;

  assign index = sram_req_i.word_addr[IndexWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (sram_req_i.req) begin
      if (sram_req_i.we) begin
        for (int b = 0; b < axil_pkg::StrbWidth; b++) begin
          if (sram_req_i.be[b]) begin
            mem[index][8*b +: 8] <= sram_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[index];
      end
    end
  end

endmodule

// File: design/debug_gate_timer.sv
// Holds the debug request off after reset so boot code runs first.
// The window closes DebugDelayCycles cycles after reset release, after
// which the request passes straight through.

`timescale 1ns/1ps

module debug_gate_timer (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(harness_pkg::DebugDelayCycles + 1);

  logic [CntWidth-1:0] count_q;

  // Counts down once per cycle and parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      count_q <= CntWidth'(harness_pkg::DebugDelayCycles);
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign debug_req_o = (count_q == '0) & debug_req_i;

endmodule

// File: design/harness_pkg.sv
// Memory map and memory-side types of the test harness.
// The bridge decodes against these regions and talks to each memory
// through one mem_req_t. The debug delay length also lives here.

package harness_pkg;

  // --------------------------------------------------------------------------
  // Memory map
  // --------------------------------------------------------------------------
  localparam logic [axil_pkg::AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [axil_pkg::AddrWidth-1:0] RomLength  = 32'h0000_1000;
  localparam logic [axil_pkg::AddrWidth-1:0] SramBase   = 32'h8000_0000;
  localparam logic [axil_pkg::AddrWidth-1:0] SramLength = 32'h0000_4000;

  // 64-bit words in each memory
  localparam int unsigned RomWords  = RomLength / (axil_pkg::DataWidth / 8);
  localparam int unsigned SramWords = SramLength / (axil_pkg::DataWidth / 8);

  // Sized for the larger of the two memories
  localparam int unsigned WordAddrWidth = 11;

  // Upper half of every ROM word starts from this value
  localparam logic [31:0] RomSignature = 32'hB007_0000;

  // Cycles after reset release before a debug request may pass
  localparam int unsigned DebugDelayCycles = 64;

  // --------------------------------------------------------------------------
  // Bridge to memory request
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                              req;
    logic                              we;
    logic [WordAddrWidth-1:0]          word_addr;
    logic [axil_pkg::StrbWidth-1:0]    be;
    logic [axil_pkg::DataWidth-1:0]    wdata;
  } mem_req_t;

endpackage

// File: design/mem_harness_top.sv
// Top of the harness memory side. One AXI4-Lite port reaches the boot
// ROM and the SRAM through the bridge, and the debug request passes
// through the post-reset delay window.

`timescale 1ns/1ps

module mem_harness_top (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  axil_pkg::axil_req_t  axil_req_i,
  output axil_pkg::axil_resp_t axil_resp_o,
  input  logic                 debug_req_i,
  output logic                 debug_req_o
);

  harness_pkg::mem_req_t          rom_req;
  harness_pkg::mem_req_t          sram_req;
  logic [axil_pkg::DataWidth-1:0] rom_rdata;
  logic [axil_pkg::DataWidth-1:0] sram_rdata;

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  axil_mem_bridge i_bridge (
    .clk_i        ( clk_i       ),
    .ndmreset_n   ( ndmreset_n  ),
    .axil_req_i   ( axil_req_i  ),
    .axil_resp_o  ( axil_resp_o ),
    .rom_req_o    ( rom_req     ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_req_o   ( sram_req    ),
    .sram_rdata_i ( sram_rdata  )
  );

  // --------------------------------------------------------------------------
  // Memories
  // --------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i     ( clk_i     ),
    .rom_req_i ( rom_req   ),
    .rdata_o   ( rom_rdata )
  );

  data_sram i_data_sram (
    .clk_i      ( clk_i      ),
    .sram_req_i ( sram_req   ),
    .rdata_o    ( sram_rdata )
  );

  // Debug request window
  debug_gate_timer i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: project.f
design/axil_pkg.sv
design/harness_pkg.sv
design/axil_mem_bridge.sv
design/boot_rom.sv
design/data_sram.sv
design/debug_gate_timer.sv
design/mem_harness_top.sv
testbench/tb_clock_gen.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f project.f --Mdir obj_dir -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the testbench.
// Makes a 4 ns clock and holds the reset low for the first 8 cycles.

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic ndmreset_n_o
);

  localparam int unsigned HalfPeriod  = 2;
  localparam int unsigned ResetCycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release lands 1 ns after a rising edge, clear of the next one
  initial begin
    ndmreset_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    ndmreset_n_o = 1'b1;
  end

endmodule

// File: testbench/tb_top.sv
// Directed testbench for the harness memory side. Each test drives the
// AXI4-Lite port or the debug request of the DUT and checks the answer
// against the memory map, the ROM rule and a byte model of the SRAM.
// Inputs change 1 ns after a rising edge, outputs are sampled at the
// falling edge.

`timescale 1ns/1ps

module tb_top;

  localparam int unsigned TimeoutCycles = 20;

  logic                 clk;
  logic                 ndmreset_n;
  axil_pkg::axil_req_t  axil_req;
  axil_pkg::axil_resp_t axil_resp;
  logic                 debug_req_i;
  logic                 debug_req_o;

  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned cycles_since_release;
  int          seed;
  logic [63:0] sram_model [int];

  tb_clock_gen i_clock_gen (
    .clk_o        ( clk        ),
    .ndmreset_n_o ( ndmreset_n )
  );

  mem_harness_top dut0 (
    .clk_i       ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .axil_req_i  ( axil_req    ),
    .axil_resp_o ( axil_resp   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // Rising edges since reset release
  always @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles_since_release <= 0;
    end else begin
      cycles_since_release <= cycles_since_release + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Checks and expected values
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      error_count++;
      $display("%s", what);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout while waiting for %s", what);
  endtask

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  strb);
    logic [63:0] word;
    word = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // Signature plus index on top, inverted index below
  function automatic logic [63:0] rom_word(input int unsigned idx);
    logic [31:0] i32;
    i32 = idx;
    return {harness_pkg::RomSignature + i32, ~i32};
  endfunction

  function automatic logic request_ready(input bit is_write);
    if (is_write) begin
      return axil_resp.aw_ready & axil_resp.w_ready;
    end
    return axil_resp.ar_ready;
  endfunction

  function automatic logic response_valid(input bit is_write);
    if (is_write) begin
      return axil_resp.b_valid;
    end
    return axil_resp.r_valid;
  endfunction

  // --------------------------------------------------------------------------
  // Bus helpers, all entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic next_drive();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_accept(input bit is_write, output bit ok);
    int unsigned waited;
    waited = 0;
    ok = 1'b1;
    @(negedge clk);
    while (ok && !request_ready(is_write)) begin
      if (waited == TimeoutCycles) begin
        report_timeout(is_write ? "the write handshake" : "the read handshake");
        ok = 1'b0;
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    next_drive();
  endtask

  // Stops at the falling edge where the response valid is first seen
  task automatic wait_response(input bit is_write, output int unsigned latency,
                               output bit ok);
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!response_valid(is_write) && latency < TimeoutCycles);
    ok = response_valid(is_write);
    if (!ok) begin
      report_timeout(is_write ? "the write response" : "the read response");
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input axil_pkg::axil_resp_e exp_resp);
    bit          ok;
    int unsigned latency;
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    axil_req.b_ready  = 1'b1;
    wait_accept(1'b1, ok);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    if (ok) begin
      wait_response(1'b1, latency, ok);
      if (ok) begin
        check_true(latency == 1, $sformatf(
          "b_valid rose %0d cycles after the write handshake instead of 1", latency));
        check_value("b_resp", axil_resp.b_resp, exp_resp);
      end
      next_drive();
    end
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic [63:0] exp_data,
                           input axil_pkg::axil_resp_e exp_resp);
    bit          ok;
    int unsigned latency;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = 1'b1;
    wait_accept(1'b0, ok);
    axil_req.ar_valid = 1'b0;
    if (ok) begin
      wait_response(1'b0, latency, ok);
      if (ok) begin
        check_true(latency == 2, $sformatf(
          "r_valid rose %0d cycles after the read handshake instead of 2", latency));
        check_value("r_data", axil_resp.r_data, exp_data);
        check_value("r_resp", axil_resp.r_resp, exp_resp);
      end
      next_drive();
    end
    axil_req.r_ready = 1'b0;
  endtask

  // Keeps ready low while a new read waits, then lets the response go
  task automatic hold_response(input bit is_write, input int unsigned delay,
                               input logic [31:0] next_addr,
                               input logic [63:0] exp_data,
                               input axil_pkg::axil_resp_e exp_resp);
    next_drive();
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = next_addr;
    for (int unsigned c = 0; c < delay; c++) begin
      @(negedge clk);
      check_value("ar_ready", axil_resp.ar_ready, 1'b0);
      if (is_write) begin
        check_value("b_valid", axil_resp.b_valid, 1'b1);
        check_value("b_resp", axil_resp.b_resp, exp_resp);
      end else begin
        check_value("r_valid", axil_resp.r_valid, 1'b1);
        check_value("r_data", axil_resp.r_data, exp_data);
        check_value("r_resp", axil_resp.r_resp, exp_resp);
      end
      next_drive();
    end
    axil_req.b_ready = is_write;
    axil_req.r_ready = !is_write;
    @(negedge clk);
    check_true(response_valid(is_write), "response valid dropped before ready was raised");
    next_drive();
    axil_req.b_ready = 1'b0;
    axil_req.r_ready = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic check_idle_outputs();
    check_value("aw_ready", axil_resp.aw_ready, 1'b0);
    check_value("w_ready", axil_resp.w_ready, 1'b0);
    check_value("ar_ready", axil_resp.ar_ready, 1'b0);
    check_value("b_valid", axil_resp.b_valid, 1'b0);
    check_value("r_valid", axil_resp.r_valid, 1'b0);
    check_value("debug_req_o", debug_req_o, 1'b0);
  endtask

  task automatic test_reset_state();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    check_true(!ndmreset_n, "reset was not asserted at the start of the run");
    check_idle_outputs();
    while (!ndmreset_n && waited < TimeoutCycles) begin
      @(negedge clk);
      waited++;
    end
    if (!ndmreset_n) begin
      report_timeout("reset release");
    end
    check_idle_outputs();
  endtask

  // Entered at the falling edge right after reset release
  task automatic test_debug_gate();
    while (cycles_since_release < harness_pkg::DebugDelayCycles - 1) begin
      @(negedge clk);
      check_value("debug_req_o", debug_req_o, 1'b0);
    end
    while (!debug_req_o && cycles_since_release < harness_pkg::DebugDelayCycles + 1) begin
      @(negedge clk);
    end
    if (!debug_req_o) begin
      report_timeout("debug_req_o to open after the delay window");
    end
    next_drive();
    debug_req_i = 1'b0;
    @(negedge clk);
    check_value("debug_req_o", debug_req_o, 1'b0);
    next_drive();
    debug_req_i = 1'b1;
    @(negedge clk);
    check_value("debug_req_o", debug_req_o, 1'b1);
    next_drive();
    debug_req_i = 1'b0;
  endtask

  task automatic test_sram_round_trip();
    int unsigned idx [8];
    logic [63:0] data;
    logic [7:0]  strb;
    logic [31:0] addr;
    idx[0] = 0;
    idx[7] = harness_pkg::SramWords - 1;
    for (int i = 1; i < 7; i++) begin
      idx[i] = $unsigned($random(seed)) % harness_pkg::SramWords;
    end
    // Full words first, low address bits are don't care
    for (int i = 0; i < 8; i++) begin
      data = {$random(seed), $random(seed)};
      addr = harness_pkg::SramBase + idx[i] * 8 + ($unsigned($random(seed)) % 8);
      axil_write(addr, data, 8'hFF, axil_pkg::OKAY);
      sram_model[idx[i]] = data;
    end
    for (int i = 0; i < 4; i++) begin
      data = {$random(seed), $random(seed)};
      strb = $random(seed);
      axil_write(harness_pkg::SramBase + idx[i] * 8, data, strb, axil_pkg::OKAY);
      sram_model[idx[i]] = merge_bytes(sram_model[idx[i]], data, strb);
    end
    for (int i = 0; i < 8; i++) begin
      axil_read(harness_pkg::SramBase + idx[i] * 8, sram_model[idx[i]], axil_pkg::OKAY);
    end
  endtask

  task automatic test_rom();
    int unsigned idx [5];
    idx = '{0, 1, 37, 256, harness_pkg::RomWords - 1};
    for (int i = 0; i < 5; i++) begin
      axil_read(harness_pkg::RomBase + idx[i] * 8, rom_word(idx[i]), axil_pkg::OKAY);
    end
    axil_write(harness_pkg::RomBase + 5 * 8, {$random(seed), $random(seed)}, 8'hFF,
               axil_pkg::SLVERR);
    axil_read(harness_pkg::RomBase + 5 * 8, rom_word(5), axil_pkg::OKAY);
  endtask

  task automatic test_unmapped();
    logic [31:0] holes [4];
    holes = '{32'h0000_0000, harness_pkg::RomBase + harness_pkg::RomLength,
              harness_pkg::SramBase + harness_pkg::SramLength, 32'h4000_0000};
    for (int i = 0; i < 4; i++) begin
      axil_read(holes[i], 64'h0, axil_pkg::DECERR);
    end
    axil_write(holes[0], 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, axil_pkg::DECERR);
    axil_write(holes[2], 64'h1234_5678_9ABC_DEF0, 8'h0F, axil_pkg::DECERR);
  endtask

  task automatic test_back_pressure();
    bit          ok;
    int unsigned latency;
    int unsigned delay;
    logic [63:0] data;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    addr_a = harness_pkg::SramBase + 200 * 8;
    addr_b = harness_pkg::SramBase + 201 * 8;
    axil_write(addr_b, 64'h0123_4567_89AB_CDEF, 8'hFF, axil_pkg::OKAY);
    sram_model[201] = 64'h0123_4567_89AB_CDEF;

    // Write response held, then a waiting read checks the written word
    delay = ($unsigned($random(seed)) % 10) + 1;
    data  = {$random(seed), $random(seed)};
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr_a;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = 8'hFF;
    axil_req.b_ready  = 1'b0;
    wait_accept(1'b1, ok);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    sram_model[200] = data;
    if (ok) begin
      wait_response(1'b1, latency, ok);
    end
    if (ok) begin
      check_value("b_resp", axil_resp.b_resp, axil_pkg::OKAY);
      hold_response(1'b1, delay, addr_a, 64'h0, axil_pkg::OKAY);
      axil_read(addr_a, sram_model[200], axil_pkg::OKAY);
    end

    // Read response held while the next read waits
    delay = ($unsigned($random(seed)) % 10) + 1;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr_a;
    axil_req.r_ready  = 1'b0;
    wait_accept(1'b0, ok);
    axil_req.ar_valid = 1'b0;
    if (ok) begin
      wait_response(1'b0, latency, ok);
    end
    if (ok) begin
      check_value("r_data", axil_resp.r_data, sram_model[200]);
      hold_response(1'b0, delay, addr_b, sram_model[200], axil_pkg::OKAY);
      axil_read(addr_b, sram_model[201], axil_pkg::OKAY);
    end
  endtask

  initial begin
    seed          = 95116;
    error_count   = 0;
    timeout_count = 0;
    axil_req      = '0;
    debug_req_i   = 1'b1;

    test_reset_state();
    test_debug_gate();
    test_sram_round_trip();
    test_rom();
    test_unmapped();
    test_back_pressure();

    $display("checks failed: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
